/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_sha256_miner_core
FILELIST = tb.f
BUILD    = obj_dir
PASS_MSG = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# The run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD)

/* hw/sha256_comp_round.sv */
// ========================================
// SHA-256 compression round
// One round on the working state, result
// registered on a pipeline step
// ========================================

`timescale 1ns/1ps

module sha256_comp_round #(
	parameter int ROUND = 4
) (
	input  logic               CLK,
	input  logic               RST,
	input  logic               advance_i,
	input  sha256_pkg::word_t  w_i,
	input  sha256_pkg::state_t state_i,
	output sha256_pkg::state_t state_o
);
	import sha256_pkg::*;

	localparam word_t round_k = k_table[ROUND];

	word_t a;
	word_t b;
	word_t c;
	word_t d;
	word_t e;
	word_t f;
	word_t g;
	word_t h;
	word_t t1;
	word_t t2;

	assign {a, b, c, d, e, f, g, h} = state_i;

	assign t1 = h + bsig1(e) + ch(e, f, g) + round_k + w_i;
	assign t2 = bsig0(a) + maj(a, b, c);

	// New a and e take the sums, the other words slide down one place
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST)
			state_o <= '0;
		else if (advance_i)
			state_o <= {t1 + t2, a, b, c, d + t1, e, f, g};
	end

endmodule

/* hw/sha256_defs.svh */
// ========================================
// SHA-256 miner core constants
// Round range, word sizes and the fixed
// padding of an 80-byte header message
// ========================================

`ifndef SHA256_DEFS_SVH
`define SHA256_DEFS_SVH

`define SHA_WORD_W 32

// The host runs rounds 0 to 3, the core runs the rest
`define SHA_FIRST_ROUND 4
`define SHA_LAST_ROUND 63

// Words kept in the message schedule window
`define SHA_WIN_DEPTH 16

// Word 4 carries the end-of-message bit
`define SHA_PAD_FIRST 32'h8000_0000
// Word 15 holds the length, 640 bits
`define SHA_PAD_LEN 32'h0000_0280

`endif

/* hw/sha256_digest_add.sv */
// ========================================
// SHA-256 final addition
// Adds the chaining value to the working
// state and registers the digest
// ========================================

`timescale 1ns/1ps

module sha256_digest_add (
	input  logic               CLK,
	input  logic               RST,
	input  logic               advance_i,
	input  logic               valid_i,
	input  sha256_pkg::state_t state_i,
	input  sha256_pkg::state_t chain_i,
	output sha256_pkg::state_t digest_o,
	output logic               valid_o
);
	import sha256_pkg::*;

	state_t sum;

	// Word-wise modular sums with no carry between words
	always_comb begin
		for (int j = 0; j < 8; j++) begin
			sum[j] = state_i[j] + chain_i[j];
		end
	end

	// Bubbles leave a zero digest behind
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			digest_o <= '0;
			valid_o <= 1'b0;
		end else if (advance_i) begin
			valid_o <= valid_i;
			if (valid_i)
				digest_o <= sum;
			else
				digest_o <= '0;
		end
	end

endmodule

/* hw/sha256_miner_core.sv */
// ========================================
// SHA-256 miner core, second header block
// Rounds 4 to 63 plus the final addition,
// one item per pipeline step
// ========================================

`timescale 1ns/1ps

module sha256_miner_core (
	input  logic               CLK,
	input  logic               RST,
	input  logic               advance_i,
	input  logic               valid_i,
	input  sha256_pkg::block_t block_i,
	input  sha256_pkg::state_t state_i,
	input  sha256_pkg::state_t chain_i,
	output sha256_pkg::state_t digest_o,
	output logic               valid_o
);
	import sha256_pkg::*;

	state_t pipe_state;
	logic pipe_valid;

	sha256_round_pipe u_round_pipe (
		.CLK      (CLK),
		.RST      (RST),
		.advance_i(advance_i),
		.valid_i  (valid_i),
		.block_i  (block_i),
		.state_i  (state_i),
		.state_o  (pipe_state),
		.valid_o  (pipe_valid)
	);

	// Chaining value is held steady by the host while items are in flight
	sha256_digest_add u_digest_add (
		.CLK      (CLK),
		.RST      (RST),
		.advance_i(advance_i),
		.valid_i  (pipe_valid),
		.state_i  (pipe_state),
		.chain_i  (chain_i),
		.digest_o (digest_o),
		.valid_o  (valid_o)
	);

endmodule

/* hw/sha256_pkg.sv */
// ========================================
// SHA-256 shared types and helpers
// Word and bus types, round constants and
// the sigma, choice and majority functions
// ========================================

`include "sha256_defs.svh"

package sha256_pkg;

	typedef logic [`SHA_WORD_W-1:0] word_t;

	// Index 7 is a, index 0 is h
	typedef word_t [7:0] state_t;

	// Index 3 is message word 0, so word 0 sits in bits 127:96
	typedef word_t [3:0] block_t;

	// Index 0 is the newest word W[r-1], index 15 the oldest W[r-16]
	typedef word_t [`SHA_WIN_DEPTH-1:0] window_t;

	localparam word_t k_table [0:63] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	function automatic word_t rotr(input word_t x, input int unsigned n);
		return (x >> n) | (x << (`SHA_WORD_W - n));
	endfunction

	// Small sigmas feed the message schedule
	function automatic word_t ssig0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t ssig1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	// Big sigmas feed the compression round
	function automatic word_t bsig0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t bsig1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t ch(input word_t e, input word_t f, input word_t g);
		return (e & f) ^ (~e & g);
	endfunction

	function automatic word_t maj(input word_t a, input word_t b, input word_t c);
		return (a & b) ^ (a & c) ^ (b & c);
	endfunction

endpackage

/* hw/sha256_round_pipe.sv */
// ========================================
// SHA-256 round pipeline, rounds 4 to 63
// Paired schedule and compression stages
// with a valid bit travelling alongside
// ========================================

`timescale 1ns/1ps
`include "sha256_defs.svh"

module sha256_round_pipe (
	input  logic               CLK,
	input  logic               RST,
	input  logic               advance_i,
	input  logic               valid_i,
	input  sha256_pkg::block_t block_i,
	input  sha256_pkg::state_t state_i,
	output sha256_pkg::state_t state_o,
	output logic               valid_o
);
	import sha256_pkg::*;

	localparam int n_stages = `SHA_LAST_ROUND - `SHA_FIRST_ROUND + 1;

	// Entry i is what stage i reads, entry 0 comes from the inputs
	window_t win [0:n_stages-1];
	state_t st [0:n_stages];
	word_t w [0:n_stages-1];
	logic [n_stages-1:0] valid_q;

	// Words 0 to 3 are the newest four before round 4, older slots unused
	assign win[0] = {{(`SHA_WIN_DEPTH - `SHA_FIRST_ROUND){word_t'(0)}}, block_i};
	assign st[0] = state_i;

	for (genvar i = 0; i < n_stages; i++) begin : g_stage
		if (i < n_stages - 1) begin : g_sched
			sha256_sched_step #(.ROUND(`SHA_FIRST_ROUND + i)) u_sched (
				.CLK      (CLK),
				.RST      (RST),
				.advance_i(advance_i),
				.win_i    (win[i]),
				.w_o      (w[i]),
				.win_o    (win[i+1])
			);
		end else begin : g_sched_last
			// No later round needs the window after round 63
			sha256_sched_step #(.ROUND(`SHA_FIRST_ROUND + i)) u_sched (
				.CLK      (CLK),
				.RST      (RST),
				.advance_i(advance_i),
				.win_i    (win[i]),
				.w_o      (w[i]),
				.win_o    ()
			);
		end

		sha256_comp_round #(.ROUND(`SHA_FIRST_ROUND + i)) u_comp (
			.CLK      (CLK),
			.RST      (RST),
			.advance_i(advance_i),
			.w_i      (w[i]),
			.state_i  (st[i]),
			.state_o  (st[i+1])
		);
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST)
			valid_q <= '0;
		else if (advance_i)
			valid_q <= {valid_q[n_stages-2:0], valid_i};
	end

	assign state_o = st[n_stages];
	assign valid_o = valid_q[n_stages-1];

endmodule

/* hw/sha256_sched_step.sv */
// ========================================
// SHA-256 message schedule stage
// Yields W[ROUND] and registers the window
// shifted by one word
// ========================================

`timescale 1ns/1ps
`include "sha256_defs.svh"

module sha256_sched_step #(
	parameter int ROUND = 4
) (
	input  logic                CLK,
	input  logic                RST,
	input  logic                advance_i,
	input  sha256_pkg::window_t win_i,
	output sha256_pkg::word_t   w_o,
	output sha256_pkg::window_t win_o
);
	import sha256_pkg::*;

	word_t w;

	// Words 4 to 15 are fixed padding, word 4 being the first round here
	always_comb begin
		if (ROUND == `SHA_FIRST_ROUND)
			w = `SHA_PAD_FIRST;
		else if (ROUND == `SHA_WIN_DEPTH - 1)
			w = `SHA_PAD_LEN;
		else if (ROUND < `SHA_WIN_DEPTH)
			w = '0;
		else
			w = ssig1(win_i[1]) + win_i[6] + ssig0(win_i[14]) + win_i[15];
	end

	assign w_o = w;

	// Oldest word drops out, this round's word becomes the newest
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST)
			win_o <= '0;
		else if (advance_i)
			win_o <= {win_i[`SHA_WIN_DEPTH-2:0], w};
	end

endmodule

/* tb.f */
+incdir+hw
+incdir+verification
hw/sha256_pkg.sv
hw/sha256_sched_step.sv
hw/sha256_comp_round.sv
hw/sha256_round_pipe.sv
hw/sha256_digest_add.sv
hw/sha256_miner_core.sv
verification/tb_sha256_miner_core.sv

/* verification/sha256_ref.svh */
// ========================================
// SHA-256 reference model for the testbench
// Rounds 4 to 63 of the second header block,
// plus the Galois LFSR for random stimulus
// ========================================

`ifndef SHA256_REF_SVH
`define SHA256_REF_SVH

function automatic word_t rotate_right(input word_t x, input int n);
	logic [63:0] doubled;
	doubled = {x, x};
	return word_t'(doubled >> n);
endfunction

function automatic word_t small_sigma0(input word_t x);
	return rotate_right(x, 7) ^ rotate_right(x, 18) ^ (x >> 3);
endfunction

function automatic word_t small_sigma1(input word_t x);
	return rotate_right(x, 17) ^ rotate_right(x, 19) ^ (x >> 10);
endfunction

function automatic word_t big_sigma0(input word_t x);
	return rotate_right(x, 2) ^ rotate_right(x, 13) ^ rotate_right(x, 22);
endfunction

function automatic word_t big_sigma1(input word_t x);
	return rotate_right(x, 6) ^ rotate_right(x, 11) ^ rotate_right(x, 25);
endfunction

// Bitwise select, e picks f where set and g where clear
function automatic word_t choose(input word_t e, input word_t f, input word_t g);
	return (e & f) | (~e & g);
endfunction

function automatic word_t majority(input word_t a, input word_t b, input word_t c);
	return (a & b) | (a & c) | (b & c);
endfunction

// Full schedule from words 0 to 3 and the padding, then rounds 4 to 63
function automatic state_t expected_digest(input block_t blk, input state_t init,
		input state_t chain);
	word_t w [0:63];
	word_t v [0:7];
	word_t t1;
	word_t t2;
	state_t out;
	int t;
	for (t = 0; t < 4; t++)
		w[t] = blk[3 - t];
	w[4] = `SHA_PAD_FIRST;
	for (t = 5; t < 15; t++)
		w[t] = '0;
	w[15] = `SHA_PAD_LEN;
	for (t = 16; t < 64; t++)
		w[t] = small_sigma1(w[t-2]) + w[t-7] + small_sigma0(w[t-15]) + w[t-16];
	// v[0] is a, v[7] is h
	for (t = 0; t < 8; t++)
		v[t] = init[7 - t];
	for (t = 4; t < 64; t++) begin
		t1 = v[7] + big_sigma1(v[4]) + choose(v[4], v[5], v[6]) + k_table[t] + w[t];
		t2 = big_sigma0(v[0]) + majority(v[0], v[1], v[2]);
		v[7] = v[6];
		v[6] = v[5];
		v[5] = v[4];
		v[4] = v[3] + t1;
		v[3] = v[2];
		v[2] = v[1];
		v[1] = v[0];
		v[0] = t1 + t2;
	end
	for (t = 0; t < 8; t++)
		out[7 - t] = v[t] + chain[7 - t];
	return out;
endfunction

// Right-shift Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ 32'h8020_0003;
	else
		return s >> 1;
endfunction

`endif

/* verification/tb_sha256_miner_core.sv */
// ========================================
// Testbench for the SHA-256 miner core
// Random items against a reference model,
// with bubbles and pipeline stalls
// ========================================

`timescale 1ns/1ps
`include "sha256_defs.svh"

module tb_sha256_miner_core;
	import sha256_pkg::*;

	`include "sha256_ref.svh"

	localparam int latency = 61;
	localparam int drain_limit = 100;

	logic CLK;
	logic RST;
	logic advance_i;
	logic valid_i;
	block_t block_i;
	state_t state_i;
	state_t chain_i;
	state_t digest_o;
	logic valid_o;

	logic [31:0] lfsr_state;

	// Expected digests and the advance count at which each item was driven
	state_t exp_q [$];
	int entry_q [$];

	int adv_count;
	int accepted;
	int results;
	int mismatch_count;
	int other_count;

	logic prev_adv;
	logic prev_valid;
	state_t prev_digest;
	logic exp_valid;
	state_t exp_digest;

	sha256_miner_core UUT (
		.CLK      (CLK),
		.RST      (RST),
		.advance_i(advance_i),
		.valid_i  (valid_i),
		.block_i  (block_i),
		.state_i  (state_i),
		.chain_i  (chain_i),
		.digest_o (digest_o),
		.valid_o  (valid_o)
	);

	always #20 CLK = ~CLK;

	// One LFSR step per bit taken, newest bit lands in bit 0
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	function automatic block_t random_block();
		block_t b;
		for (int i = 0; i < 4; i++)
			b[i] = random_bits(32);
		return b;
	endfunction

	function automatic state_t random_state();
		state_t s;
		for (int i = 0; i < 8; i++)
			s[i] = random_bits(32);
		return s;
	endfunction

	task automatic check_digest(input state_t got, input state_t exp, input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_valid(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	// Drives one cycle from the falling edge; an accepted item goes on the queue
	task automatic step_cycle(input logic adv, input logic vld);
		@(negedge CLK);
		advance_i = adv;
		valid_i = vld;
		block_i = random_block();
		state_i = random_state();
		if (adv && vld) begin
			exp_q.push_back(expected_digest(block_i, state_i, chain_i));
			entry_q.push_back(adv_count);
			accepted++;
		end
	endtask

	task automatic drain(input string phase);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < drain_limit) begin
			step_cycle(1'b1, 1'b0);
			n++;
		end
		if (exp_q.size() != 0) begin
			other_count++;
			$display("Timeout in %s: %0d results never came out", phase, exp_q.size());
			exp_q.delete();
			entry_q.delete();
		end
	endtask

	// The consumer takes a result on a step with valid_o high
	always @(posedge CLK) begin
		if (RST) begin
			if (!prev_adv) begin
				check_valid(valid_o, prev_valid, "valid_o moved during a stall");
				check_digest(digest_o, prev_digest, "digest_o moved during a stall");
			end
			if (advance_i) begin
				exp_valid = 1'b0;
				if (exp_q.size() != 0)
					exp_valid = (adv_count - entry_q[0] == latency);
				check_valid(valid_o, exp_valid, "valid_o at a step");
				if (valid_o && exp_q.size() != 0) begin
					exp_digest = exp_q.pop_front();
					void'(entry_q.pop_front());
					check_digest(digest_o, exp_digest, "digest of the oldest item");
					results++;
				end else if (valid_o) begin
					other_count++;
					$display("Result at %0t with no item outstanding", $time);
				end else begin
					check_digest(digest_o, '0, "digest_o of a bubble");
				end
				adv_count++;
			end
			prev_adv = advance_i;
			prev_valid = valid_o;
			prev_digest = digest_o;
		end
	end

	initial begin
		logic [31:0] r;
		CLK = 1'b0;
		RST = 1'b0;
		advance_i = 1'b0;
		valid_i = 1'b0;
		block_i = '0;
		state_i = '0;
		lfsr_state = 32'h6b7c_e5f4;
		adv_count = 0;
		accepted = 0;
		results = 0;
		mismatch_count = 0;
		other_count = 0;
		prev_adv = 1'b1;
		prev_valid = 1'b0;
		prev_digest = '0;
		// Chaining value stays fixed for the whole run
		chain_i = random_state();

		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b1;
		check_valid(valid_o, 1'b0, "valid_o after reset");
		check_digest(digest_o, '0, "digest_o after reset");

		// Idle steps, then one lone item
		repeat (10) step_cycle(1'b1, 1'b0);
		step_cycle(1'b1, 1'b1);
		drain("single item");

		repeat (100) step_cycle(1'b1, 1'b1);
		drain("back-to-back stream");

		repeat (200) begin
			r = random_bits(1);
			step_cycle(1'b1, r[0]);
		end
		drain("valid gaps");

		// Stalls of up to 7 cycles where the offered items are not taken
		repeat (150) begin
			r = random_bits(3);
			repeat (r[2:0]) step_cycle(1'b0, 1'b1);
			r = random_bits(1);
			step_cycle(1'b1, r[0]);
		end
		drain("advance stalls");

		if (results != accepted) begin
			other_count++;
			$display("Got %0d results for %0d accepted items", results, accepted);
		end

		$display("Errors: %0d mismatches, %0d other failures; %0d results for %0d items",
			mismatch_count, other_count, results, accepted);
		if (mismatch_count == 0 && other_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
